//--- verilog/uart_defs_pkg.sv
// Serial framing constants and the byte type for the UART bridge.
// Import this package into any block that handles serial bytes
// or counts frame bits.

package uart_defs_pkg;

  // --------------------
  // Frame layout
  // --------------------

  // Data bits per frame, LSB sent first
  localparam int DATA_BITS = 8;

  // One start bit, the data bits and one stop bit
  localparam int FRAME_BITS = DATA_BITS + 2;

  // --------------------
  // Byte type
  // --------------------

  // One data byte as it travels over the line or through memory
  typedef logic [DATA_BITS-1:0] uart_byte_t;

endpackage

//--- verilog/cmd_pkg.sv
// Command encoding for the serial memory bridge.
// A command byte carries a two-bit opcode in its top bits and a
// six-bit memory address below it.

package cmd_pkg;

  // --------------------
  // Address and opcodes
  // --------------------

  // Six address bits give 64 byte locations
  typedef logic [5:0] mem_addr_t;

  // Opcode in bits 7:6 of the command byte
  typedef enum logic [1:0] {
    OP_NOP   = 2'b00,
    OP_WRITE = 2'b01,
    OP_READ  = 2'b10,
    OP_RSVD  = 2'b11
  } cmd_op_t;

  // --------------------
  // Received byte views
  // --------------------

  // Command view, op lands in the upper two bits
  typedef struct packed {
    cmd_op_t   op;
    mem_addr_t addr;
  } cmd_fields_t;

  // Same byte seen as raw data or as a command
  typedef union packed {
    uart_defs_pkg::uart_byte_t data;
    cmd_fields_t               cmd;
  } cmd_word_u;

endpackage

//--- verilog/baud_tick_gen.sv
// Baud tick generator for the UART receiver and transmitter.
// Pulses tick once every BAUD_DIV clocks while en is high.
// With half_first set the first tick arrives after half a bit.

`timescale 1ns/1ns

module baud_tick_gen #(
  parameter int BAUD_DIV = 8
) (
  input  logic clk,
  input  logic rstn,
  input  logic en,
  input  logic half_first,
  output logic tick
);

  // Counter wide enough for BAUD_DIV-1
  localparam int CW = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

  logic [CW-1:0] cnt;
  logic [CW-1:0] preset;

  // Start value while idle
  // Half a period in for mid-bit sampling, else a full period
  assign preset = half_first ? CW'(BAUD_DIV / 2) : '0;

  // --------------------
  // Divider
  // --------------------

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt <= '0;
    end else if (!en) begin
      cnt <= preset;
    end else if (tick) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Last count of the period
  assign tick = en && (cnt == CW'(BAUD_DIV - 1));

endmodule

//--- verilog/uart_rx.sv
// UART receiver, 8 data bits, one stop bit, no parity.
// A falling edge on the registered line starts a frame. The byte
// appears on rx_data with a one-cycle rx_valid strobe.

`timescale 1ns/1ns

module uart_rx
  import uart_defs_pkg::*;
#(
  parameter int BAUD_DIV = 8
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       serial_in,
  output logic       rx_valid,
  output uart_byte_t rx_data
);

  // FSM encoding
  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] RECV = 2'd1;
  localparam logic [1:0] LOAD = 2'd2;
  localparam logic [1:0] DAV  = 2'd3;

  logic [1:0]            state;
  logic [1:0]            next_state;
  logic                  rx_r;
  logic                  tick;
  logic [3:0]            bitc;
  logic [FRAME_BITS-1:0] raw;

  // --------------------
  // Datapath
  // --------------------

  // Line register, idles high
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rx_r <= 1'b1;
    end else begin
      rx_r <= serial_in;
    end
  end

  // Ticks only during a frame, first one mid start bit
  baud_tick_gen #(
    .BAUD_DIV(BAUD_DIV)
  ) u_tick (
    .clk       (clk),
    .rstn      (rstn),
    .en        (state == RECV),
    .half_first(1'b1),
    .tick      (tick)
  );

  // Bit counter, held at zero while idle
  always_ff @(posedge clk) begin
    if (!rstn || state == IDLE) begin
      bitc <= '0;
    end else if (tick) begin
      bitc <= bitc + 1'b1;
    end
  end

  // Shift in LSB first
  // After a full frame raw[0] is the start bit
  always_ff @(posedge clk) begin
    if (tick) begin
      raw <= {rx_r, raw[FRAME_BITS-1:1]};
    end
  end

  // Data bits between start and stop
  always_ff @(posedge clk) begin
    if (state == LOAD) begin
      rx_data <= raw[DATA_BITS:1];
    end
  end

  // --------------------
  // Control FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      // Wait for a start bit
      IDLE: if (!rx_r) next_state = RECV;
      // Leave on the stop bit sample
      RECV: if (tick && bitc == 4'(FRAME_BITS - 1)) next_state = LOAD;
      LOAD: next_state = DAV;
      default: next_state = IDLE;
    endcase
  end

  // Strobe for one cycle after the load
  assign rx_valid = (state == DAV);

endmodule

//--- verilog/uart_tx.sv
// UART transmitter, 8 data bits, one stop bit, no parity.
// Pulse tx_start with the byte on tx_data while tx_busy is low.
// tx_busy stays high until the stop bit has been sent.

`timescale 1ns/1ns

module uart_tx
  import uart_defs_pkg::*;
#(
  parameter int BAUD_DIV = 8
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       tx_start,
  input  uart_byte_t tx_data,
  output logic       serial_out,
  output logic       tx_busy
);

  logic                  tick;
  logic                  load;
  logic                  last;
  logic [3:0]            bitc;
  logic [FRAME_BITS-1:0] frame;

  // Start requests during a frame are dropped
  assign load = tx_start && !tx_busy;

  // Tick at the end of the stop bit
  assign last = tick && (bitc == 4'(FRAME_BITS - 1));

  // Full bit periods from the frame start
  baud_tick_gen #(
    .BAUD_DIV(BAUD_DIV)
  ) u_tick (
    .clk       (clk),
    .rstn      (rstn),
    .en        (tx_busy),
    .half_first(1'b0),
    .tick      (tick)
  );

  // --------------------
  // Frame shifter
  // --------------------

  // Stop, data and start bits, LSB goes out first
  always_ff @(posedge clk) begin
    if (load) begin
      frame <= {1'b1, tx_data, 1'b0};
    end else if (tick) begin
      frame <= {1'b1, frame[FRAME_BITS-1:1]};
    end
  end

  // Bits already sent in this frame
  always_ff @(posedge clk) begin
    if (!rstn || load) begin
      bitc <= '0;
    end else if (tick) begin
      bitc <= bitc + 1'b1;
    end
  end

  // --------------------
  // Line and busy
  // --------------------

  always_ff @(posedge clk) begin
    if (!rstn) begin
      serial_out <= 1'b1;
      tx_busy    <= 1'b0;
    end else if (load) begin
      // Start bit on the next cycle
      serial_out <= 1'b0;
      tx_busy    <= 1'b1;
    end else if (last) begin
      serial_out <= 1'b1;
      tx_busy    <= 1'b0;
    end else if (tick) begin
      serial_out <= frame[1];
    end
  end

endmodule

//--- verilog/cmd_engine.sv
// Command engine between the UART and the shared memory.
// Write is a command byte then a data byte; read sends the stored
// byte back on the transmitter. NOP and reserved bytes are dropped.

`timescale 1ns/1ns

module cmd_engine
  import uart_defs_pkg::*;
  import cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  logic       rx_valid,
  input  uart_byte_t rx_data,
  input  logic       tx_busy,
  output logic       tx_start,
  output uart_byte_t tx_data,
  output logic       mem_req,
  output logic       mem_we,
  output mem_addr_t  mem_addr,
  output uart_byte_t mem_wdata,
  input  logic       mem_gnt,
  input  uart_byte_t mem_rdata
);

  // FSM encoding
  localparam logic [2:0] S_CMD   = 3'd0;
  localparam logic [2:0] S_DATA  = 3'd1;
  localparam logic [2:0] S_WREQ  = 3'd2;
  localparam logic [2:0] S_RREQ  = 3'd3;
  localparam logic [2:0] S_RWAIT = 3'd4;
  localparam logic [2:0] S_REPLY = 3'd5;

  logic [2:0] state;
  cmd_word_u  rx_word;

  // Received byte, decoded by the state that reads it
  assign rx_word = cmd_word_u'(rx_data);

  // --------------------
  // Control FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= S_CMD;
    end else begin
      case (state)
        S_CMD: begin
          if (rx_valid) begin
            case (rx_word.cmd.op)
              OP_WRITE: state <= S_DATA;
              OP_READ:  state <= S_RREQ;
              // No memory access for these
              OP_NOP, OP_RSVD: state <= S_CMD;
              default: state <= S_CMD;
            endcase
          end
        end
        // Next byte is the write data
        S_DATA:  if (rx_valid) state <= S_WREQ;
        S_WREQ:  if (mem_gnt) state <= S_CMD;
        S_RREQ:  if (mem_gnt) state <= S_RWAIT;
        // Read data lands this cycle
        S_RWAIT: state <= S_REPLY;
        // Hold here while the line is in use
        S_REPLY: if (!tx_busy) state <= S_CMD;
        default: state <= S_CMD;
      endcase
    end
  end

  // --------------------
  // Operand registers
  // --------------------

  // Address from the command view
  always_ff @(posedge clk) begin
    if (state == S_CMD && rx_valid) begin
      mem_addr <= rx_word.cmd.addr;
    end
  end

  // Payload from the data view
  always_ff @(posedge clk) begin
    if (state == S_DATA && rx_valid) begin
      mem_wdata <= rx_word.data;
    end
  end

  // Reply byte, kept until the transmitter takes it
  always_ff @(posedge clk) begin
    if (state == S_RWAIT) begin
      tx_data <= mem_rdata;
    end
  end

  // --------------------
  // Outputs
  // --------------------

  assign mem_req  = (state == S_WREQ) || (state == S_RREQ);
  assign mem_we   = (state == S_WREQ);
  assign tx_start = (state == S_REPLY) && !tx_busy;

endmodule

//--- verilog/shared_mem.sv
// 64-byte register memory shared by two requesters.
// Hold req and operands until gnt; writes land on the gnt cycle,
// read data follows one cycle later. Ties alternate a and b.

`timescale 1ns/1ns

module shared_mem
  import uart_defs_pkg::*;
  import cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  logic       a_req,
  input  logic       a_we,
  input  mem_addr_t  a_addr,
  input  uart_byte_t a_wdata,
  output logic       a_gnt,
  output uart_byte_t a_rdata,
  input  logic       b_req,
  input  logic       b_we,
  input  mem_addr_t  b_addr,
  input  uart_byte_t b_wdata,
  output logic       b_gnt,
  output uart_byte_t b_rdata
);

  localparam int DEPTH = 2 ** $bits(mem_addr_t);

  uart_byte_t mem [DEPTH];
  logic       last_b;

  // --------------------
  // Arbiter
  // --------------------

  // Lone requests win at once, ties go to the port not served last
  assign a_gnt = a_req && (!b_req || last_b);
  assign b_gnt = b_req && (!a_req || !last_b);

  // b counts as last served out of reset
  always_ff @(posedge clk) begin
    if (!rstn) begin
      last_b <= 1'b1;
    end else if (a_gnt) begin
      last_b <= 1'b0;
    end else if (b_gnt) begin
      last_b <= 1'b1;
    end
  end

  // --------------------
  // Storage
  // --------------------

  // Grants are exclusive so only one write per cycle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (a_gnt && a_we) begin
      mem[a_addr] <= a_wdata;
    end else if (b_gnt && b_we) begin
      mem[b_addr] <= b_wdata;
    end
  end

  // Per-port read data, held until that port's next read
  always_ff @(posedge clk) begin
    if (a_gnt && !a_we) begin
      a_rdata <= mem[a_addr];
    end
    if (b_gnt && !b_we) begin
      b_rdata <= mem[b_addr];
    end
  end

endmodule

//--- verilog/uart_mem_bridge.sv
// Top level of the UART memory bridge.
// The serial command path owns memory port a, the parallel ext_*
// port owns port b. BAUD_DIV sets clocks per serial bit.

`timescale 1ns/1ns

module uart_mem_bridge
  import uart_defs_pkg::*;
  import cmd_pkg::*;
#(
  parameter int BAUD_DIV = 8
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       serial_in,
  input  logic       ext_req,
  input  logic       ext_we,
  input  mem_addr_t  ext_addr,
  input  uart_byte_t ext_wdata,
  output logic       serial_out,
  output logic       ext_gnt,
  output uart_byte_t ext_rdata,
  output logic       ext_rvalid
);

  logic       rx_valid;
  uart_byte_t rx_data;
  logic       tx_start;
  uart_byte_t tx_data;
  logic       tx_busy;
  logic       eng_req;
  logic       eng_we;
  mem_addr_t  eng_addr;
  uart_byte_t eng_wdata;
  logic       eng_gnt;
  uart_byte_t eng_rdata;

  // --------------------
  // Serial path
  // --------------------

  uart_rx #(
    .BAUD_DIV(BAUD_DIV)
  ) u_rx (
    .clk      (clk),
    .rstn     (rstn),
    .serial_in(serial_in),
    .rx_valid (rx_valid),
    .rx_data  (rx_data)
  );

  uart_tx #(
    .BAUD_DIV(BAUD_DIV)
  ) u_tx (
    .clk       (clk),
    .rstn      (rstn),
    .tx_start  (tx_start),
    .tx_data   (tx_data),
    .serial_out(serial_out),
    .tx_busy   (tx_busy)
  );

  cmd_engine u_engine (
    .clk      (clk),
    .rstn     (rstn),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .tx_busy  (tx_busy),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .mem_req  (eng_req),
    .mem_we   (eng_we),
    .mem_addr (eng_addr),
    .mem_wdata(eng_wdata),
    .mem_gnt  (eng_gnt),
    .mem_rdata(eng_rdata)
  );

  // --------------------
  // Shared memory
  // --------------------

  shared_mem u_mem (
    .clk    (clk),
    .rstn   (rstn),
    .a_req  (eng_req),
    .a_we   (eng_we),
    .a_addr (eng_addr),
    .a_wdata(eng_wdata),
    .a_gnt  (eng_gnt),
    .a_rdata(eng_rdata),
    .b_req  (ext_req),
    .b_we   (ext_we),
    .b_addr (ext_addr),
    .b_wdata(ext_wdata),
    .b_gnt  (ext_gnt),
    .b_rdata(ext_rdata)
  );

  // Marks the cycle ext_rdata turns valid
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ext_rvalid <= 1'b0;
    end else begin
      ext_rvalid <= ext_gnt && !ext_we;
    end
  end

endmodule

//--- sim/uart_mem_bridge_chk.sv
// Concurrent assertions on the memory arbiter and the UART transmit line.
// Bound into the bridge top level, where both memory ports and the
// transmitter outputs are visible.

`timescale 1ns/1ns

module uart_mem_bridge_chk (
  input logic clk,
  input logic rstn,
  input logic a_req,
  input logic a_gnt,
  input logic b_req,
  input logic b_gnt,
  input logic tx_busy,
  input logic serial_out
);

  // Failed assertions so far
  int unsigned fail_count = 0;

  // --------------------
  // Arbiter
  // --------------------

  grant_exclusive: assert property (@(posedge clk) disable iff (!rstn) !(a_gnt && b_gnt))
    else begin
      $error("port a and port b granted in the same cycle");
      fail_count = fail_count + 1;
    end

  // A request that lost a tie stays up and wins the next cycle
  grant_a_next: assert property (@(posedge clk) disable iff (!rstn) a_req && !a_gnt |=> a_gnt)
    else begin
      $error("port a request not granted on the cycle after it lost");
      fail_count = fail_count + 1;
    end

  grant_b_next: assert property (@(posedge clk) disable iff (!rstn) b_req && !b_gnt |=> b_gnt)
    else begin
      $error("port b request not granted on the cycle after it lost");
      fail_count = fail_count + 1;
    end

  // --------------------
  // Transmit line
  // --------------------

  // Line idles high between frames
  line_idle_high: assert property (@(posedge clk) disable iff (!rstn) !tx_busy |-> serial_out)
    else begin
      $error("serial_out low while the transmitter is idle");
      fail_count = fail_count + 1;
    end

endmodule

bind uart_mem_bridge uart_mem_bridge_chk u_chk (
  .clk       (clk),
  .rstn      (rstn),
  .a_req     (eng_req),
  .a_gnt     (eng_gnt),
  .b_req     (ext_req),
  .b_gnt     (ext_gnt),
  .tx_busy   (tx_busy),
  .serial_out(serial_out)
);

//--- sim/tb_uart_mem_bridge.sv
// Testbench for the UART memory bridge.
// Reads operations and expected bytes from sim/bridge_cases.txt, drives
// serial frames and the parallel port, and checks every read result.
// An LCG background pattern is written and read back before the cases.

`timescale 1ns/1ns

module tb_uart_mem_bridge
  import uart_defs_pkg::*;
  import cmd_pkg::*;
();

  localparam int          BAUD_DIV  = 8;
  localparam int          DRIVE_DLY = 10;
  localparam int          BG_COUNT  = 16;
  localparam mem_addr_t   BG_BASE   = 6'h30;
  localparam logic [31:0] SEED      = 32'hb72c_96be;
  // Engine request after a two-byte write, two cycles past the stop bit
  // middle plus one, counted from the first start bit
  localparam int          REQ_DLY   = 2 * FRAME_BITS * BAUD_DIV - 1;

  logic       clk;
  logic       rstn;
  logic       serial_in;
  logic       ext_req;
  logic       ext_we;
  mem_addr_t  ext_addr;
  uart_byte_t ext_wdata;
  logic       serial_out;
  logic       ext_gnt;
  uart_byte_t ext_rdata;
  logic       ext_rvalid;

  // Case table, filled before the clock starts
  logic [15:0] kinds [$];
  int unsigned arg_a [$];
  int unsigned arg_b [$];

  // Expected memory contents
  uart_byte_t  model [64];
  int unsigned cycles = 0;
  int unsigned cycle_limit = 0;
  logic [31:0] lcg;
  mem_addr_t   bg_addr;
  uart_byte_t  got;

  uart_mem_bridge #(
    .BAUD_DIV(BAUD_DIV)
  ) u_dut (
    .clk       (clk),
    .rstn      (rstn),
    .serial_in (serial_in),
    .ext_req   (ext_req),
    .ext_we    (ext_we),
    .ext_addr  (ext_addr),
    .ext_wdata (ext_wdata),
    .serial_out(serial_out),
    .ext_gnt   (ext_gnt),
    .ext_rdata (ext_rdata),
    .ext_rvalid(ext_rvalid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run length guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout: run still busy after %0d clock cycles", cycles);
      stop_run();
    end
  end

  // --------------------
  // Helpers
  // --------------------

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  // x(n+1) = a*x(n) + c, 32-bit wrap
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Opcode in the top two bits, address below
  function automatic uart_byte_t make_cmd(input cmd_op_t op, input mem_addr_t addr);
    return {op, addr};
  endfunction

  task automatic next_edge();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Mid-cycle, all outputs settled
  task automatic next_sample();
    @(negedge clk);
  endtask

  task automatic check_reply(input mem_addr_t addr, input uart_byte_t rcv, input uart_byte_t exp);
    if (rcv !== exp) begin
      $display("FAIL at %0t ns: serial reply for addr 0x%02h is 0x%02h, expected 0x%02h",
               $time, addr, rcv, exp);
      stop_run();
    end
  endtask

  task automatic check_rdata(input mem_addr_t addr, input uart_byte_t rcv, input uart_byte_t exp);
    if (rcv !== exp) begin
      $display("FAIL at %0t ns: parallel read of addr 0x%02h is 0x%02h, expected 0x%02h",
               $time, addr, rcv, exp);
      stop_run();
    end
  endtask

  task automatic check_level(input string what, input logic rcv, input logic exp);
    if (rcv !== exp) begin
      $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, rcv, exp);
      stop_run();
    end
  endtask

  // --------------------
  // Serial side
  // --------------------

  // Start, 8 data bits LSB first, stop; BAUD_DIV cycles per bit
  task automatic send_byte(input uart_byte_t b);
    logic [FRAME_BITS-1:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++) begin
      serial_in = frame[i];
      repeat (BAUD_DIV) next_edge();
    end
  endtask

  // Line idle, lets the engine finish its memory access
  task automatic idle_bits(input int n);
    serial_in = 1'b1;
    repeat (n * BAUD_DIV) next_edge();
  endtask

  task automatic serial_write(input mem_addr_t addr, input uart_byte_t data);
    send_byte(make_cmd(OP_WRITE, addr));
    send_byte(data);
  endtask

  // Find the start bit, then sample each bit at its middle
  task automatic capture_reply(output uart_byte_t rcv);
    rcv = '0;
    next_sample();
    while (serial_out !== 1'b0) begin
      next_sample();
    end
    repeat (BAUD_DIV / 2) next_sample();
    if (serial_out !== 1'b0) begin
      $display("Reply start bit went high before its middle at %0t ns", $time);
      stop_run();
    end else begin
      for (int i = 0; i < DATA_BITS; i++) begin
        repeat (BAUD_DIV) next_sample();
        rcv[i] = serial_out;
      end
      repeat (BAUD_DIV) next_sample();
      if (serial_out !== 1'b1) begin
        $display("Reply stop bit was low at %0t ns", $time);
        stop_run();
      end else begin
        // Rest of the stop bit
        repeat (BAUD_DIV / 2) next_edge();
      end
    end
  endtask

  task automatic serial_read(input mem_addr_t addr, output uart_byte_t rcv);
    send_byte(make_cmd(OP_READ, addr));
    capture_reply(rcv);
  endtask

  // --------------------
  // Parallel side
  // --------------------

  // Request held until gnt, dropped after the granted edge
  task automatic wait_grant();
    next_sample();
    while (ext_gnt !== 1'b1) begin
      next_sample();
    end
    next_edge();
    ext_req = 1'b0;
    ext_we  = 1'b0;
  endtask

  task automatic parallel_write(input mem_addr_t addr, input uart_byte_t data);
    ext_req   = 1'b1;
    ext_we    = 1'b1;
    ext_addr  = addr;
    ext_wdata = data;
    wait_grant();
  endtask

  task automatic parallel_read(input mem_addr_t addr, output uart_byte_t rcv);
    ext_req  = 1'b1;
    ext_we   = 1'b0;
    ext_addr = addr;
    wait_grant();
    next_sample();
    while (ext_rvalid !== 1'b1) begin
      next_sample();
    end
    rcv = ext_rdata;
    next_edge();
  endtask

  // --------------------
  // Cases file
  // --------------------

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    logic [15:0] kind;
    int unsigned a;
    int unsigned b;
    fd = $fopen("sim/bridge_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the cases file sim/bridge_cases.txt");
      stop_run();
    end else begin
      while (!$feof(fd)) begin
        n    = $fgets(line, fd);
        kind = '0;
        if (n > 0) begin
          n = $sscanf(line, "%s %h %h", kind, a, b);
        end
        // Blank and comment lines are skipped
        if (n >= 1 && kind[7:0] != "#") begin
          if (n != 3) begin
            $display("Cases file line has fewer than three fields: %s", line);
            stop_run();
          end else begin
            kinds.push_back(kind);
            arg_a.push_back(a);
            arg_b.push_back(b);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_case(input logic [15:0] kind, input int unsigned a, input int unsigned b);
    mem_addr_t  addr;
    mem_addr_t  peer;
    uart_byte_t data;
    uart_byte_t rcv;
    addr = mem_addr_t'(a);
    data = uart_byte_t'(b);
    // Parallel side of a simultaneous write
    peer = addr ^ 6'h20;
    case (kind)
      "SW": begin
        serial_write(addr, data);
        idle_bits(1);
        model[addr] = data;
      end
      "SR": begin
        serial_read(addr, rcv);
        check_reply(addr, rcv, data);
      end
      "PW": begin
        parallel_write(addr, data);
        model[addr] = data;
      end
      "PR": begin
        parallel_read(addr, rcv);
        check_rdata(addr, rcv, data);
      end
      "XX": begin
        fork
          serial_write(addr, data);
          begin
            // Rises in the cycle the engine requests port a
            repeat (REQ_DLY) next_edge();
            parallel_write(peer, ~data);
          end
        join
        idle_bits(1);
        model[addr] = data;
        model[peer] = ~data;
        parallel_read(addr, rcv);
        check_rdata(addr, rcv, model[addr]);
        serial_read(peer, rcv);
        check_reply(peer, rcv, model[peer]);
      end
      "NP": begin
        if (a != 0 && a != 3) begin
          $display("Cases file NP line has opcode %0h, which is a real command", a);
          stop_run();
        end else begin
          send_byte(make_cmd(cmd_op_t'(a[1:0]), mem_addr_t'(b)));
          idle_bits(1);
        end
      end
      default: begin
        $display("Cases file holds an unknown operation kind %s", kind);
        stop_run();
      end
    endcase
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    rstn      = 1'b0;
    serial_in = 1'b1;
    ext_req   = 1'b0;
    ext_we    = 1'b0;
    ext_addr  = '0;
    ext_wdata = '0;
    foreach (model[i]) begin
      model[i] = '0;
    end
    load_cases();
    // Three frames per case, background and reset sweep counted as cases
    cycle_limit = (kinds.size() + BG_COUNT + 2) * 3 * FRAME_BITS * BAUD_DIV + 200;
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    rstn = 1'b1;

    // Idle outputs, then every location reads zero
    next_sample();
    check_level("serial_out", serial_out, 1'b1);
    check_level("ext_gnt", ext_gnt, 1'b0);
    check_level("ext_rvalid", ext_rvalid, 1'b0);
    next_edge();
    for (int i = 0; i < 64; i++) begin
      parallel_read(mem_addr_t'(i), got);
      check_rdata(mem_addr_t'(i), got, 8'h00);
    end

    // LCG background in the top quarter of memory
    lcg = SEED;
    for (int i = 0; i < BG_COUNT; i++) begin
      lcg            = lcg_next(lcg);
      bg_addr        = BG_BASE + mem_addr_t'(i);
      model[bg_addr] = lcg[23:16];
      parallel_write(bg_addr, lcg[23:16]);
    end
    for (int i = 0; i < BG_COUNT; i++) begin
      bg_addr = BG_BASE + mem_addr_t'(i);
      parallel_read(bg_addr, got);
      check_rdata(bg_addr, got, model[bg_addr]);
      // Every fourth value also over the serial line
      if (i % 4 == 0) begin
        serial_read(bg_addr, got);
        check_reply(bg_addr, got, model[bg_addr]);
      end
    end

    for (int i = 0; i < kinds.size(); i++) begin
      run_case(kinds[i], arg_a[i], arg_b[i]);
    end

    if (u_dut.u_chk.fail_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Bound checker saw %0d assertion failures", u_dut.u_chk.fail_count);
      stop_run();
    end
  end

endmodule

//--- sim/bridge_cases.txt
# kind addr data, all hex; for SR and PR data is the expected byte
# kind NP takes opcode then addr; XX also writes ~data to addr^20 in parallel
SW 01 a5
PR 01 a5
SW 02 3c
PR 02 3c
PW 05 5a
SR 05 5a
PW 06 81
SR 06 81
SW 07 00
SR 07 00
XX 03 96
XX 08 e1
PW 0a 77
NP 0 0a
NP 3 0a
PR 0a 77
SR 0a 77
NP 3 0b
SR 0b 00
SW 0c ff
PR 0c ff
SR 01 a5

//--- uart_mem_bridge.f
verilog/uart_defs_pkg.sv
verilog/cmd_pkg.sv
verilog/baud_tick_gen.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/cmd_engine.sv
verilog/shared_mem.sv
verilog/uart_mem_bridge.sv
sim/uart_mem_bridge_chk.sv
sim/tb_uart_mem_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the bridge testbench with Verilator, run it, and check the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtb_uart_mem_bridge

verilator --binary --timing --assert \
  --top-module tb_uart_mem_bridge \
  -f uart_mem_bridge.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
